// ==== rtl/ebox_pkg.sv ====
// Integer subset only: no PAL, privileged, floating point or multimedia opcodes are known here
package ebox_pkg;

  localparam int XLEN   = 64;  // Data and address width
  localparam int REG_AW = 5;   // Register file address width

  localparam logic [5:0] OP_NOP   = 6'h00;  // All-zero word is a bubble
  localparam logic [5:0] OP_LDA   = 6'h08;
  localparam logic [5:0] OP_LDAH  = 6'h09;
  localparam logic [5:0] OP_LDBU  = 6'h0A;
  localparam logic [5:0] OP_LDQ_U = 6'h0B;
  localparam logic [5:0] OP_LDWU  = 6'h0C;
  localparam logic [5:0] OP_INTA  = 6'h10;  // Add, sub, scaled, compare
  localparam logic [5:0] OP_INTL  = 6'h11;  // Logical
  localparam logic [5:0] OP_INTS  = 6'h12;  // Mask, extract, insert, zap, shift
  localparam logic [5:0] OP_INTM  = 6'h13;  // Multiply
  localparam logic [5:0] OP_JMP   = 6'h1A;  // Register jump
  localparam logic [5:0] OP_FPTI  = 6'h1C;  // Sign extend
  localparam logic [5:0] OP_LDL   = 6'h28;
  localparam logic [5:0] OP_LDQ   = 6'h29;
  localparam logic [5:0] OP_LDL_L = 6'h2A;
  localparam logic [5:0] OP_LDQ_L = 6'h2B;

  typedef struct packed {
    logic [5:0]        opcode;
    logic [REG_AW-1:0] ra;
    logic [REG_AW-1:0] rb;
    logic [15:0]       lo;  // Displacement, or func and rc
  } inst_t;

  localparam inst_t NOP_INST = '{opcode: OP_NOP, default: '0};

  typedef struct packed {
    logic [5:0] shift_amt;    // Pre-shift of operand A
    logic [1:0] shift_mode;
    logic [4:0] alu_op;
    logic [2:0] cmp_op;
    logic [4:0] mask_op;      // {ins, ext, size, high}
    logic [2:0] ext_op;       // Load zero extension
    logic       shift_sel;
    logic       invert_b;
    logic [2:0] result_sel;
    logic [1:0] zap_op;
    logic       overflow_trap;
  } ctrl_word_t;

  typedef enum logic [1:0] {FWD_REG, FWD_EX, FWD_MEM, FWD_LOAD} fwd_sel_e;

  typedef struct packed {
    logic              en;
    logic [REG_AW-1:0] addr;
  } wb_t;

  function automatic logic [6:0] func_of(inst_t i);
    return i.lo[11:5];
  endfunction

  function automatic logic [REG_AW-1:0] rc_of(inst_t i);
    return i.lo[4:0];
  endfunction

  function automatic logic is_load(inst_t i);
    return i.opcode inside {OP_LDA, OP_LDAH, OP_LDBU, OP_LDQ_U, OP_LDWU,
                            OP_LDL, OP_LDQ, OP_LDL_L, OP_LDQ_L};
  endfunction

  function automatic logic is_oper(inst_t i);
    return i.opcode inside {OP_INTA, OP_INTL, OP_INTS, OP_INTM, OP_FPTI};
  endfunction

  function automatic logic is_jump(inst_t i);
    return i.opcode == OP_JMP;
  endfunction

  // Both top opcode bits set
  function automatic logic is_branch(inst_t i);
    return i.opcode[5:4] == 2'b11;
  endfunction

endpackage

// ==== rtl/branch_cond.sv ====
// Integer branches only; reg_a must already be the forwarded value, FP branches never take
`timescale 1ns/1ps

module branch_cond (
  input  ebox_pkg::inst_t             s2,
  input  logic [ebox_pkg::XLEN-1:0]   reg_a,
  output logic                        taken
);
  import ebox_pkg::*;

  logic neg;
  logic zero;
  logic cond;

  assign neg  = reg_a[XLEN-1];
  assign zero = (reg_a == '0);

  always_comb begin
    case (s2.opcode[3:0])
      4'h0, 4'h4: cond = 1'b1;           // BR, BSR
      4'h8:       cond = ~reg_a[0];      // BLBC
      4'h9:       cond = zero;           // BEQ
      4'hA:       cond = neg;            // BLT
      4'hB:       cond = zero | neg;     // BLE
      4'hC:       cond = reg_a[0];       // BLBS
      4'hD:       cond = ~zero;          // BNE
      4'hE:       cond = zero | ~neg;    // BGE
      4'hF:       cond = ~zero & ~neg;   // BGT
      default:    cond = 1'b0;
    endcase
  end

  assign taken = is_branch(s2) & cond;

endmodule

// ==== rtl/fetch_pc.sv ====
// RESET_PC must be word aligned; a redirect wins over hold even during a stall
`timescale 1ns/1ps

module fetch_pc #(
  parameter logic [ebox_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                        clk,
  input  logic                        arst_n,
  input  ebox_pkg::inst_t             s2,
  input  logic [ebox_pkg::XLEN-1:0]   reg_b,
  input  logic                        taken,
  input  logic                        hold,
  input  logic                        redirect_jump,
  output logic [ebox_pkg::XLEN-1:0]   pc
);
  import ebox_pkg::*;

  logic [20:0]     disp;
  logic [XLEN-1:0] br_target;
  logic [XLEN-1:0] jmp_target;
  logic [XLEN-1:0] pc_next;

  assign disp       = {s2.rb, s2.lo};  // 21-bit word displacement
  assign br_target  = pc + {{(XLEN-23){disp[20]}}, disp, 2'b00};
  assign jmp_target = {reg_b[XLEN-1:2], 2'b00};

  always_comb begin
    if (taken)
      pc_next = br_target;
    else if (redirect_jump)
      pc_next = jmp_target;
    else if (hold)
      pc_next = pc;  // Branch in s2 also lands here when not taken
    else
      pc_next = pc + XLEN'(4);
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)
      pc <= RESET_PC;
    else
      pc <= pc_next;
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n)
    pc[1:0] == 2'b00)
    else $error("pc lost word alignment");

endmodule

// ==== rtl/inst_pipe.sv ====
// Stages 2 to 5; d_stall outranks the load-use interlock, which outranks bubbles
`timescale 1ns/1ps

module inst_pipe (
  input  logic            clk,
  input  logic            arst_n,
  input  ebox_pkg::inst_t inst,
  input  logic            i_stall,
  input  logic            d_stall,
  input  logic            taken,
  output ebox_pkg::inst_t s2,
  output ebox_pkg::inst_t s3,
  output ebox_pkg::inst_t s4,
  output ebox_pkg::inst_t s5,
  output logic            hold,
  output logic            redirect_jump,
  output ebox_pkg::wb_t   wb
);
  import ebox_pkg::*;

  logic s2_branch;
  logic s2_jump;
  logic interlock;
  logic kill_s2;

  assign s2_branch = is_branch(s2);
  assign s2_jump   = is_jump(s2);

  // Load in s3 feeds a source field of s2
  assign interlock = is_load(s3) && (s2.ra == s3.ra || s2.rb == s3.ra);

  assign kill_s2       = s2_branch | s2_jump | i_stall;
  assign hold          = s2_branch | i_stall | d_stall | interlock;
  assign redirect_jump = s2_jump & ~interlock;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s2 <= NOP_INST;
      s3 <= NOP_INST;
      s4 <= NOP_INST;
      s5 <= NOP_INST;
    end else if (!d_stall) begin  // Full freeze otherwise
      s4 <= s3;
      s5 <= s4;
      if (interlock) begin
        s3 <= NOP_INST;  // s2 waits for the load
      end else begin
        s3 <= s2;
        s2 <= kill_s2 ? NOP_INST : inst;
      end
    end
  end

  // Operates write rc, loads and jumps write ra
  assign wb.en   = is_oper(s5) | is_load(s5) | is_jump(s5);
  assign wb.addr = is_oper(s5) ? rc_of(s5) : s5.ra;

  a_dstall_freeze: assert property (@(posedge clk) disable iff (!arst_n)
    d_stall |=> $stable({s2, s3, s4, s5}))
    else $error("stage moved under d_stall");

  a_interlock_bubble: assert property (@(posedge clk) disable iff (!arst_n)
    interlock && !d_stall |=> s3 == NOP_INST)
    else $error("no bubble after load-use interlock");

endmodule

// ==== rtl/bypass_sel.sv ====
// Priority is stage 3 result, stage 4 result, stage 4 load data, then register file
`timescale 1ns/1ps

module bypass_sel (
  input  ebox_pkg::inst_t    s2,
  input  ebox_pkg::inst_t    s3,
  input  ebox_pkg::inst_t    s4,
  output ebox_pkg::fwd_sel_e fwd_a,
  output ebox_pkg::fwd_sel_e fwd_b
);
  import ebox_pkg::*;

  // Does s produce a result for register src
  function automatic logic writes_reg(inst_t s, logic [REG_AW-1:0] src);
    return (is_oper(s) && rc_of(s) == src) || (is_jump(s) && s.ra == src);
  endfunction

  function automatic fwd_sel_e pick(logic [REG_AW-1:0] src, inst_t ex, inst_t mem);
    fwd_sel_e sel;
    if (writes_reg(ex, src))
      sel = FWD_EX;
    else if (writes_reg(mem, src))
      sel = FWD_MEM;
    else if (is_load(mem) && mem.ra == src)
      sel = FWD_LOAD;  // Load data arrives a stage late
    else
      sel = FWD_REG;
    return sel;
  endfunction

  assign fwd_a = pick(s2.ra, s3, s4);
  assign fwd_b = pick(s2.rb, s3, s4);

endmodule

// ==== rtl/ctrl_decode.sv ====
// Little-endian loads only; conditional moves, counts and packed-byte ops decode to zero
`timescale 1ns/1ps

module ctrl_decode (
  input  ebox_pkg::inst_t     s3,
  output ebox_pkg::ctrl_word_t ex_ctrl
);
  import ebox_pkg::*;

  logic [6:0] func;

  assign func = func_of(s3);

  function automatic ctrl_word_t arith(logic [5:0] sa, logic [4:0] alu, logic [2:0] cmp,
                                       logic [2:0] rs, logic v);
    return '{shift_amt: sa, alu_op: alu, cmp_op: cmp, result_sel: rs, overflow_trap: v,
             default: '0};
  endfunction

  always_comb begin
    casez ({s3.opcode, func})
      {OP_LDA, 7'b???????}, {OP_LDQ, 7'b???????}, {OP_LDQ_L, 7'b???????}:
        ex_ctrl = arith(6'h00, 5'h1, 3'h0, 3'h0, 1'b0);
      {OP_LDAH, 7'b???????}:  ex_ctrl = arith(6'h10, 5'h1, 3'h0, 3'h0, 1'b0);
      {OP_LDQ_U, 7'b???????}: ex_ctrl = arith(6'h00, 5'h1, 3'h0, 3'h3, 1'b0);
      {OP_LDBU, 7'b???????}:  ex_ctrl = '{alu_op: 5'h1, ext_op: 3'h7, default: '0};
      {OP_LDWU, 7'b???????}:  ex_ctrl = '{alu_op: 5'h1, ext_op: 3'h6, default: '0};
      {OP_LDL, 7'b???????}, {OP_LDL_L, 7'b???????}:
        ex_ctrl = '{alu_op: 5'h1, ext_op: 3'h4, default: '0};

      {OP_INTA, 7'h00}: ex_ctrl = arith(6'd0, 5'h1, 3'h0, 3'h1, 1'b0);  // ADDL
      {OP_INTA, 7'h02}: ex_ctrl = arith(6'd2, 5'h1, 3'h0, 3'h1, 1'b0);  // S4ADDL
      {OP_INTA, 7'h09}: ex_ctrl = arith(6'd0, 5'h2, 3'h0, 3'h1, 1'b0);  // SUBL
      {OP_INTA, 7'h0B}: ex_ctrl = arith(6'd2, 5'h2, 3'h0, 3'h1, 1'b0);  // S4SUBL
      {OP_INTA, 7'h0F}: ex_ctrl = arith(6'd0, 5'h6, 3'h0, 3'h0, 1'b0);  // CMPBGE
      {OP_INTA, 7'h12}: ex_ctrl = arith(6'd3, 5'h1, 3'h0, 3'h1, 1'b0);  // S8ADDL
      {OP_INTA, 7'h1B}: ex_ctrl = arith(6'd3, 5'h2, 3'h0, 3'h1, 1'b0);  // S8SUBL
      {OP_INTA, 7'h1D}: ex_ctrl = arith(6'd0, 5'h2, 3'h5, 3'h2, 1'b0);  // CMPULT
      {OP_INTA, 7'h20}: ex_ctrl = arith(6'd0, 5'h1, 3'h0, 3'h0, 1'b0);  // ADDQ
      {OP_INTA, 7'h22}: ex_ctrl = arith(6'd2, 5'h1, 3'h0, 3'h0, 1'b0);  // S4ADDQ
      {OP_INTA, 7'h29}: ex_ctrl = arith(6'd0, 5'h2, 3'h0, 3'h0, 1'b0);  // SUBQ
      {OP_INTA, 7'h2B}: ex_ctrl = arith(6'd2, 5'h2, 3'h0, 3'h0, 1'b0);  // S4SUBQ
      {OP_INTA, 7'h2D}: ex_ctrl = arith(6'd0, 5'h2, 3'h2, 3'h2, 1'b0);  // CMPEQ
      {OP_INTA, 7'h32}: ex_ctrl = arith(6'd3, 5'h1, 3'h0, 3'h0, 1'b0);  // S8ADDQ
      {OP_INTA, 7'h3B}: ex_ctrl = arith(6'd3, 5'h2, 3'h0, 3'h0, 1'b0);  // S8SUBQ
      {OP_INTA, 7'h3D}: ex_ctrl = arith(6'd0, 5'h2, 3'h6, 3'h2, 1'b0);  // CMPULE
      {OP_INTA, 7'h40}: ex_ctrl = arith(6'd0, 5'h1, 3'h0, 3'h1, 1'b1);  // ADDL/V
      {OP_INTA, 7'h49}: ex_ctrl = arith(6'd0, 5'h2, 3'h0, 3'h1, 1'b1);  // SUBL/V
      {OP_INTA, 7'h4D}: ex_ctrl = arith(6'd0, 5'h2, 3'h0, 3'h2, 1'b0);  // CMPLT
      {OP_INTA, 7'h60}: ex_ctrl = arith(6'd0, 5'h1, 3'h0, 3'h0, 1'b1);  // ADDQ/V
      {OP_INTA, 7'h69}: ex_ctrl = arith(6'd0, 5'h2, 3'h0, 3'h0, 1'b1);  // SUBQ/V
      {OP_INTA, 7'h6D}: ex_ctrl = arith(6'd0, 5'h2, 3'h3, 3'h2, 1'b0);  // CMPLE

      {OP_INTL, 7'h00}: ex_ctrl = '{alu_op: 5'h3, default: '0};                 // AND
      {OP_INTL, 7'h08}: ex_ctrl = '{alu_op: 5'h3, invert_b: 1'b1, default: '0}; // BIC
      {OP_INTL, 7'h20}: ex_ctrl = '{alu_op: 5'h4, default: '0};                 // BIS
      {OP_INTL, 7'h28}: ex_ctrl = '{alu_op: 5'h4, invert_b: 1'b1, default: '0}; // ORNOT
      {OP_INTL, 7'h40}: ex_ctrl = '{alu_op: 5'h5, default: '0};                 // XOR
      {OP_INTL, 7'h48}: ex_ctrl = '{alu_op: 5'h5, invert_b: 1'b1, default: '0}; // EQV

      // Byte ops take their size from func[5:4] and the high half from func[6]
      {OP_INTS, 7'h02}, {OP_INTS, 7'h12}, {OP_INTS, 7'h22}, {OP_INTS, 7'h32},
      {OP_INTS, 7'h52}, {OP_INTS, 7'h62}, {OP_INTS, 7'h72}:  // MSKxx
        ex_ctrl = '{mask_op: {2'b00, func[5:4], func[6]}, result_sel: 3'h4, default: '0};
      {OP_INTS, 7'h06}, {OP_INTS, 7'h16}, {OP_INTS, 7'h26}, {OP_INTS, 7'h36},
      {OP_INTS, 7'h5A}, {OP_INTS, 7'h6A}, {OP_INTS, 7'h7A}:  // EXTxx
        ex_ctrl = '{mask_op: {2'b01, func[5:4], func[6]}, result_sel: 3'h4, default: '0};
      {OP_INTS, 7'h0B}, {OP_INTS, 7'h1B}, {OP_INTS, 7'h2B}, {OP_INTS, 7'h3B},
      {OP_INTS, 7'h57}, {OP_INTS, 7'h67}, {OP_INTS, 7'h77}:  // INSxx
        ex_ctrl = '{mask_op: {2'b10, func[5:4], func[6]}, result_sel: 3'h4, default: '0};
      {OP_INTS, 7'h30}: ex_ctrl = '{result_sel: 3'h4, zap_op: 2'h1, default: '0};  // ZAP
      {OP_INTS, 7'h31}: ex_ctrl = '{result_sel: 3'h4, zap_op: 2'h2, default: '0};  // ZAPNOT
      {OP_INTS, 7'h34}: ex_ctrl = '{shift_mode: 2'h2, shift_sel: 1'b1, default: '0}; // SRL
      {OP_INTS, 7'h39}: ex_ctrl = '{shift_mode: 2'h0, shift_sel: 1'b1, default: '0}; // SLL
      {OP_INTS, 7'h3C}: ex_ctrl = '{shift_mode: 2'h3, shift_sel: 1'b1, default: '0}; // SRA

      {OP_INTM, 7'h00}: ex_ctrl = arith(6'd0, 5'h8, 3'h0, 3'h1, 1'b0);  // MULL
      {OP_INTM, 7'h20}: ex_ctrl = arith(6'd0, 5'h7, 3'h0, 3'h0, 1'b0);  // MULQ
      {OP_INTM, 7'h30}: ex_ctrl = arith(6'd0, 5'h9, 3'h0, 3'h0, 1'b0);  // UMULH
      {OP_INTM, 7'h40}: ex_ctrl = arith(6'd0, 5'h8, 3'h0, 3'h1, 1'b1);  // MULL/V
      {OP_INTM, 7'h60}: ex_ctrl = arith(6'd0, 5'h7, 3'h0, 3'h0, 1'b1);  // MULQ/V

      {OP_FPTI, 7'h00}: ex_ctrl = arith(6'd0, 5'h0, 3'h0, 3'h6, 1'b0);  // SEXTB
      {OP_FPTI, 7'h01}: ex_ctrl = arith(6'd0, 5'h0, 3'h0, 3'h7, 1'b0);  // SEXTW

      default: ex_ctrl = '0;  // Branches, jumps, bubbles
    endcase
  end

endmodule

// ==== rtl/ebox_top.sv ====
// RESET_PC must be word aligned; reg_a and reg_b are the stage 2 operands after forwarding
`timescale 1ns/1ps

module ebox_top #(
  parameter logic [ebox_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                      clk,
  input  logic                      arst_n,
  input  ebox_pkg::inst_t           inst,
  input  logic [ebox_pkg::XLEN-1:0] reg_a,
  input  logic [ebox_pkg::XLEN-1:0] reg_b,
  input  logic                      i_stall,
  input  logic                      d_stall,
  output logic [ebox_pkg::XLEN-1:0] pc,
  output ebox_pkg::ctrl_word_t      ex_ctrl,
  output ebox_pkg::fwd_sel_e        fwd_a,
  output ebox_pkg::fwd_sel_e        fwd_b,
  output ebox_pkg::wb_t             wb
);
  import ebox_pkg::*;

  inst_t s2;
  inst_t s3;
  inst_t s4;
  logic  hold;
  logic  redirect_jump;
  logic  taken;

  fetch_pc #(.RESET_PC(RESET_PC)) fetch_pc_inst (
    .clk, .arst_n, .s2, .reg_b, .taken, .hold, .redirect_jump, .pc
  );

  inst_pipe inst_pipe_inst (
    .clk, .arst_n, .inst, .i_stall, .d_stall, .taken,
    .s2, .s3, .s4, .s5(), .hold, .redirect_jump, .wb
  );

  branch_cond branch_cond_inst (.s2, .reg_a, .taken);

  bypass_sel bypass_sel_inst (.s2, .s3, .s4, .fwd_a, .fwd_b);

  ctrl_decode ctrl_decode_inst (.s3, .ex_ctrl);

endmodule

// ==== test/ebox_model.svh ====
// Reference model of the pipeline control; the including module must import ebox_pkg first
`ifndef EBOX_MODEL_SVH
`define EBOX_MODEL_SVH

typedef struct packed {
  logic [XLEN-1:0] pc;
  inst_t           s2;
  inst_t           s3;
  inst_t           s4;
  inst_t           s5;
} model_t;

function automatic bit load_word(inst_t i);
  return i.opcode inside {6'h08, 6'h09, 6'h0A, 6'h0B, 6'h0C, [6'h28:6'h2B]};
endfunction

function automatic bit operate_word(inst_t i);
  return i.opcode inside {6'h10, 6'h11, 6'h12, 6'h13, 6'h1C};
endfunction

// Operate writes rc, jump writes ra
function automatic bit writes_src(inst_t s, logic [REG_AW-1:0] src);
  return (operate_word(s) && s.lo[4:0] == src) || (s.opcode == 6'h1A && s.ra == src);
endfunction

function automatic fwd_sel_e expected_fwd(logic [REG_AW-1:0] src, inst_t ex, inst_t mem);
  if (writes_src(ex, src))
    return FWD_EX;
  if (writes_src(mem, src))
    return FWD_MEM;
  if (load_word(mem) && mem.ra == src)
    return FWD_LOAD;
  return FWD_REG;
endfunction

function automatic wb_t wb_of(inst_t s);
  wb_t w;
  w.en   = operate_word(s) || load_word(s) || s.opcode == 6'h1A;
  w.addr = operate_word(s) ? s.lo[4:0] : s.ra;
  return w;
endfunction

// Tests against zero with the sign bit meaning less
function automatic bit branch_taken(inst_t i, logic [XLEN-1:0] a);
  bit z;
  bit n;
  z = (a == '0);
  n = a[XLEN-1];
  if (i.opcode[5:4] != 2'b11)
    return 1'b0;
  case (i.opcode[3:0])
    4'h0, 4'h4: return 1'b1;
    4'h8:       return !a[0];
    4'h9:       return z;
    4'hA:       return n;
    4'hB:       return z || n;
    4'hC:       return a[0];
    4'hD:       return !z;
    4'hE:       return z || !n;
    4'hF:       return !z && !n;
    default:    return 1'b0;  // FP branches
  endcase
endfunction

// Only the pairs the stimulus pool uses; anything else must decode to zero
function automatic ctrl_word_t decode_table(inst_t i);
  case (i.opcode)
    6'h08, 6'h29: return '{alu_op: 5'h1, default: '0};
    6'h09:        return '{shift_amt: 6'h10, alu_op: 5'h1, default: '0};
    6'h0A:        return '{alu_op: 5'h1, ext_op: 3'h7, default: '0};
    6'h28:        return '{alu_op: 5'h1, ext_op: 3'h4, default: '0};
    default: ;
  endcase
  case ({i.opcode, i.lo[11:5]})
    {6'h10, 7'h00}: return '{alu_op: 5'h1, result_sel: 3'h1, default: '0};
    {6'h10, 7'h22}: return '{shift_amt: 6'd2, alu_op: 5'h1, default: '0};
    {6'h10, 7'h69}: return '{alu_op: 5'h2, overflow_trap: 1'b1, default: '0};
    {6'h10, 7'h4D}: return '{alu_op: 5'h2, result_sel: 3'h2, default: '0};
    {6'h10, 7'h3D}: return '{alu_op: 5'h2, cmp_op: 3'h6, result_sel: 3'h2, default: '0};
    {6'h11, 7'h08}: return '{alu_op: 5'h3, invert_b: 1'b1, default: '0};
    {6'h11, 7'h40}: return '{alu_op: 5'h5, default: '0};
    {6'h12, 7'h16}: return '{mask_op: 5'h0A, result_sel: 3'h4, default: '0};  // EXTWL
    {6'h12, 7'h77}: return '{mask_op: 5'h17, result_sel: 3'h4, default: '0};  // INSQH
    {6'h12, 7'h31}: return '{result_sel: 3'h4, zap_op: 2'h2, default: '0};
    {6'h12, 7'h3C}: return '{shift_mode: 2'h3, shift_sel: 1'b1, default: '0};
    {6'h13, 7'h20}: return '{alu_op: 5'h7, default: '0};
    {6'h13, 7'h40}: return '{alu_op: 5'h8, result_sel: 3'h1, overflow_trap: 1'b1, default: '0};
    {6'h1C, 7'h01}: return '{result_sel: 3'h7, default: '0};
    default:        return '0;
  endcase
endfunction

function automatic model_t next_state(model_t m, inst_t in, logic [XLEN-1:0] a,
                                      logic [XLEN-1:0] b, logic istall, logic dstall);
  model_t      n;
  bit          br;
  bit          jmp;
  bit          lock;
  logic [20:0] disp;
  n    = m;
  br   = m.s2.opcode[5:4] == 2'b11;
  jmp  = m.s2.opcode == 6'h1A;
  lock = load_word(m.s3) && (m.s2.ra == m.s3.ra || m.s2.rb == m.s3.ra);
  disp = {m.s2.rb, m.s2.lo};
  if (branch_taken(m.s2, a))
    n.pc = m.pc + (XLEN'($signed(disp)) << 2);
  else if (jmp && !lock)
    n.pc = b & ~XLEN'(3);
  else if (!(br || istall || dstall || lock))
    n.pc = m.pc + XLEN'(4);
  if (!dstall) begin
    n.s4 = m.s3;
    n.s5 = m.s4;
    n.s3 = lock ? '0 : m.s2;
    if (!lock)
      n.s2 = (br || jmp || istall) ? '0 : in;
  end
  return n;
endfunction

`endif

// ==== test/ebox_tb.sv ====
// Random and directed streams checked each cycle against a lock-step model; no fetch memory
`timescale 1ns/1ps

module ebox_tb;
  import ebox_pkg::*;

  `include "ebox_model.svh"

  localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_0001_0000;
  localparam int N_OPER  = 40;
  localparam int N_BR    = 60;
  localparam int N_JMP   = 40;
  localparam int N_LU    = 16;   // Five words each
  localparam int N_STALL = 300;
  localparam int N_DEC   = 27;   // Pool plus flush
  localparam int CYCLE_LIMIT = 5 + N_OPER + N_BR + N_JMP + 5 * N_LU + N_STALL + N_DEC + 100;

  // 14 listed operates, 4 unlisted and 5 loads as {opcode, func}
  localparam logic [12:0] POOL [23] = '{
    {6'h10, 7'h00}, {6'h10, 7'h22}, {6'h10, 7'h69}, {6'h10, 7'h4D}, {6'h10, 7'h3D},
    {6'h11, 7'h08}, {6'h11, 7'h40}, {6'h12, 7'h16}, {6'h12, 7'h77}, {6'h12, 7'h31},
    {6'h12, 7'h3C}, {6'h13, 7'h20}, {6'h13, 7'h40}, {6'h1C, 7'h01},
    {6'h10, 7'h7F}, {6'h11, 7'h14}, {6'h12, 7'h3F}, {6'h1C, 7'h30},
    {6'h08, 7'h00}, {6'h09, 7'h00}, {6'h0A, 7'h00}, {6'h28, 7'h00}, {6'h29, 7'h00}
  };

  logic            clk = 1'b0;
  logic            arst_n;
  inst_t           inst;
  logic [XLEN-1:0] reg_a;
  logic [XLEN-1:0] reg_b;
  logic            i_stall;
  logic            d_stall;
  logic [XLEN-1:0] pc;
  ctrl_word_t      ex_ctrl;
  fwd_sel_e        fwd_a;
  fwd_sel_e        fwd_b;
  wb_t             wb;

  model_t          m;
  logic [15:0]     lfsr;
  fwd_sel_e        exp_a;
  fwd_sel_e        exp_b;
  logic            dstall_prev;
  logic [XLEN-1:0] pc_prev;
  wb_t             wb_prev;
  int errors      = 0;
  int misc_errors = 0;
  int checks      = 0;
  int cycles      = 0;
  int seen_load   = 0;
  int seen_ex     = 0;
  int seen_mem    = 0;

  ebox_top #(.RESET_PC(RESET_PC)) ebox_top_inst (
    .clk, .arst_n, .inst, .reg_a, .reg_b, .i_stall, .d_stall,
    .pc, .ex_ctrl, .fwd_a, .fwd_b, .wb
  );

  always #4 clk = ~clk;

  always @(posedge clk) cycles <= cycles + 1;

  // Taps 16, 14, 13, 11; one step per bit
  function automatic logic [XLEN-1:0] lfsr_bits(int n);
    logic [XLEN-1:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      r    = {r[XLEN-2:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [XLEN-1:0] operand_value();
    case (int'(lfsr_bits(2)))
      0:       return '0;
      1:       return {XLEN{1'b1}};
      2:       return lfsr_bits(8);
      default: return lfsr_bits(XLEN);
    endcase
  endfunction

  // Register fields drawn from the low regs bits only
  function automatic inst_t pool_word(int idx, int regs);
    inst_t i;
    i           = '0;
    i.opcode    = POOL[idx][12:7];
    i.lo[11:5]  = POOL[idx][6:0];
    i.ra        = REG_AW'(lfsr_bits(regs));
    i.rb        = REG_AW'(lfsr_bits(regs));
    i.lo[4:0]   = REG_AW'(lfsr_bits(regs));
    return i;
  endfunction

  task automatic drive(inst_t w, logic [XLEN-1:0] a, logic [XLEN-1:0] b, logic is, logic ds);
    @(posedge clk);
    inst    <= w;
    reg_a   <= a;
    reg_b   <= b;
    i_stall <= is;
    d_stall <= ds;
  endtask

  task automatic report_done(string name, int err_before);
    $display("test %s finished at cycle %0d with %0d errors", name, cycles,
             errors + misc_errors - err_before);
  endtask

  task automatic flag_error(string msg);
    $display("** Error at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic operate_stream();
    for (int k = 0; k < N_OPER; k++)
      drive(pool_word(int'(lfsr_bits(5)) % 18, 5), operand_value(), lfsr_bits(XLEN),
            1'b0, 1'b0);
  endtask

  // One word in three is a branch of random condition
  task automatic branch_mix();
    inst_t w;
    for (int k = 0; k < N_BR; k++) begin
      w = pool_word(int'(lfsr_bits(4)) % 14, 5);
      if (int'(lfsr_bits(5)) % 3 == 0) begin
        w = 32'(lfsr_bits(32));
        w.opcode[5:4] = 2'b11;
      end
      drive(w, operand_value(), lfsr_bits(XLEN), 1'b0, 1'b0);
    end
  endtask

  task automatic jump_mix();
    inst_t w;
    for (int k = 0; k < N_JMP; k++) begin
      w = pool_word(int'(lfsr_bits(4)) % 14, 5);
      if (int'(lfsr_bits(5)) % 3 == 0) begin
        w = 32'(lfsr_bits(32));
        w.opcode = 6'h1A;
      end
      drive(w, operand_value(), lfsr_bits(XLEN), 1'b0, 1'b0);
    end
  endtask

  // Load, dependent op, dropped filler, then consumers at distance one and two
  task automatic load_use_chain();
    inst_t             w;
    logic [REG_AW-1:0] r;
    int                s_load;
    int                s_ex;
    int                s_mem;
    s_load = seen_load;
    s_ex   = seen_ex;
    s_mem  = seen_mem;
    for (int k = 0; k < N_LU; k++) begin
      r = REG_AW'(lfsr_bits(5));
      w = pool_word(18 + int'(lfsr_bits(3)) % 5, 5);
      w.ra = r;
      drive(w, lfsr_bits(XLEN), lfsr_bits(XLEN), 1'b0, 1'b0);
      w = pool_word(int'(lfsr_bits(4)) % 14, 5);
      w.ra = r + 5'd3;
      w.rb = r;
      w.lo[4:0] = r + 5'd7;
      drive(w, lfsr_bits(XLEN), lfsr_bits(XLEN), 1'b0, 1'b0);
      drive('0, lfsr_bits(XLEN), lfsr_bits(XLEN), 1'b0, 1'b0);
      w = pool_word(int'(lfsr_bits(4)) % 14, 5);
      w.ra = r + 5'd7;
      w.rb = r + 5'd19;
      w.lo[4:0] = r + 5'd11;
      drive(w, lfsr_bits(XLEN), lfsr_bits(XLEN), 1'b0, 1'b0);
      w = pool_word(int'(lfsr_bits(4)) % 14, 5);
      w.ra = r + 5'd13;
      w.rb = r + 5'd7;
      w.lo[4:0] = r + 5'd17;
      drive(w, lfsr_bits(XLEN), lfsr_bits(XLEN), 1'b0, 1'b0);
    end
    if (seen_load == s_load || seen_ex == s_ex || seen_mem == s_mem) begin
      $display("The DUT never selected load, stage 3 or stage 4 forwarding in the load-use test");
      misc_errors++;
    end
  endtask

  // Four registers only, so interlocks are frequent
  task automatic stall_stream();
    for (int k = 0; k < N_STALL; k++)
      drive(pool_word(int'(lfsr_bits(5)) % 23, 2), lfsr_bits(XLEN), lfsr_bits(XLEN),
            lfsr_bits(2) == '0, lfsr_bits(2) == '0);
  endtask

  task automatic decode_sweep();
    for (int k = 0; k < 23; k++)
      drive(pool_word(k, 5), lfsr_bits(XLEN), lfsr_bits(XLEN), 1'b0, 1'b0);
    repeat (4) drive('0, '0, '0, 1'b0, 1'b0);
  endtask

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n)
      m <= '{pc: RESET_PC, default: '0};
    else
      m <= next_state(m, inst, reg_a, reg_b, i_stall, d_stall);
  end

  // Compare at the falling edge, where registers and decode have settled
  always @(negedge clk) begin
    if (arst_n) begin
      checks++;
      exp_a = expected_fwd(m.s2.ra, m.s3, m.s4);
      exp_b = expected_fwd(m.s2.rb, m.s3, m.s4);
      if (pc !== m.pc)
        flag_error($sformatf("pc is %h, expected %h", pc, m.pc));
      if (ex_ctrl !== decode_table(m.s3))
        flag_error($sformatf("ex_ctrl is %h, expected %h", ex_ctrl, decode_table(m.s3)));
      if (wb !== wb_of(m.s5))
        flag_error($sformatf("wb is %h, expected %h", wb, wb_of(m.s5)));
      if (fwd_a !== exp_a)
        flag_error($sformatf("fwd_a is %s, expected %s", fwd_a.name(), exp_a.name()));
      if (fwd_b !== exp_b)
        flag_error($sformatf("fwd_b is %s, expected %s", fwd_b.name(), exp_b.name()));
      if (dstall_prev && (pc !== pc_prev || wb !== wb_prev))
        flag_error("pc or wb moved during d_stall");
      if (fwd_a == FWD_LOAD || fwd_b == FWD_LOAD)
        seen_load++;
      if (fwd_a == FWD_EX || fwd_b == FWD_EX)
        seen_ex++;
      if (fwd_a == FWD_MEM || fwd_b == FWD_MEM)
        seen_mem++;
      dstall_prev = d_stall;
      pc_prev     = pc;
      wb_prev     = wb;
    end else begin
      dstall_prev = 1'b0;
    end
  end

  initial begin
    wait (cycles >= CYCLE_LIMIT);
    $display("Timeout: the tests did not end within %0d cycles", CYCLE_LIMIT);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    int e0;
    int total;
    arst_n  = 1'b0;
    inst    = '0;
    reg_a   = '0;
    reg_b   = '0;
    i_stall = 1'b0;
    d_stall = 1'b0;
    lfsr    = 16'd49098;
    repeat (4) @(posedge clk);
    @(negedge clk);
    if (pc !== RESET_PC || wb.en !== 1'b0 || fwd_a !== FWD_REG || fwd_b !== FWD_REG
        || ex_ctrl !== '0) begin
      $display("Outputs are not in their reset state while arst_n is low");
      misc_errors++;
    end
    @(posedge clk);
    arst_n <= 1'b1;
    e0 = errors + misc_errors;
    operate_stream();
    report_done("operate stream", e0);
    e0 = errors + misc_errors;
    branch_mix();
    report_done("branches", e0);
    e0 = errors + misc_errors;
    jump_mix();
    report_done("jumps", e0);
    e0 = errors + misc_errors;
    load_use_chain();
    report_done("load-use and forwarding", e0);
    e0 = errors + misc_errors;
    stall_stream();
    report_done("random stalls", e0);
    e0 = errors + misc_errors;
    decode_sweep();
    repeat (2) @(negedge clk);
    report_done("decode table", e0);
    total = errors + misc_errors;
    $display("checks %0d, errors %0d", checks, total);
    if (total == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== ebox.f ====
+incdir+test
rtl/ebox_pkg.sv
rtl/branch_cond.sv
rtl/fetch_pc.sv
rtl/inst_pipe.sv
rtl/bypass_sel.sv
rtl/ctrl_decode.sv
rtl/ebox_top.sv
test/ebox_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and decide pass or fail from the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module ebox_tb -f ebox.f -o ebox_sim
./obj_dir/ebox_sim | tee sim.log
if grep -q "SIMULATION PASSED" sim.log; then
  echo "run_sim: simulation run passed"
else
  echo "run_sim: simulation run did not pass"
  exit 1
fi
